// File: leaf_pkg.sv
package leaf_pkg;

    localparam int PACKET_BITS = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_ADDR_BITS = 7;

    // Data ports are numbered 1 to NUM_PORTS and array index i holds port i+1.
    localparam int NUM_PORTS = 3;
    localparam int PORT_IDX_BITS = $clog2(NUM_PORTS);

    localparam logic [NUM_LEAF_BITS-1:0] LEAF_ID = 5'd6;
    localparam logic [NUM_PORT_BITS-1:0] CFG_PORT = 4'd0;

    typedef logic [PAYLOAD_BITS-1:0] word_t;

    typedef struct packed {
        logic                     valid;
        logic [NUM_LEAF_BITS-1:0] dest_leaf;
        logic [NUM_PORT_BITS-1:0] dest_port;
        logic [NUM_ADDR_BITS-1:0] addr;
        word_t                    payload;
    } packet_t;

    typedef struct packed {
        logic [NUM_LEAF_BITS-1:0] dest_leaf;
        logic [NUM_PORT_BITS-1:0] dest_port;
    } route_t;

    typedef enum logic {
        SLOT_IDLE,
        SLOT_BUSY
    } slot_state_t;

endpackage

// File: leaf_rx_router.sv
module leaf_rx_router (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  leaf_pkg::packet_t                            din_leaf_bft2interface,
    input  logic                                         ap_start,
    input  logic [leaf_pkg::NUM_PORTS-1:0]               ack_user2interface,
    output leaf_pkg::word_t  [leaf_pkg::NUM_PORTS-1:0]   dout_leaf_interface2user,
    output logic [leaf_pkg::NUM_PORTS-1:0]               vld_interface2user,
    output leaf_pkg::route_t [leaf_pkg::NUM_PORTS-1:0]   route,
    output logic                                         run
);
    import leaf_pkg::*;

    logic                 for_me;
    logic [NUM_PORTS-1:0] data_hit;
    logic [NUM_PORTS-1:0] data_load;
    logic [NUM_PORTS-1:0] cfg_load;
    logic [NUM_PORTS-1:0] full_q;
    word_t [NUM_PORTS-1:0] word_q;

    assign for_me = din_leaf_bft2interface.valid &&
                    (din_leaf_bft2interface.dest_leaf == LEAF_ID);

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            data_hit[i] = for_me &&
                          (din_leaf_bft2interface.dest_port == NUM_PORT_BITS'(i + 1));
            // A slot that is acked at this edge can take the next word at once.
            data_load[i] = data_hit[i] && (!full_q[i] || ack_user2interface[i]);
            cfg_load[i] = for_me && (din_leaf_bft2interface.dest_port == CFG_PORT) &&
                          (din_leaf_bft2interface.addr == NUM_ADDR_BITS'(i + 1));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= '0;
            route  <= '0;
            run    <= 1'b0;
        end else begin
            if (ap_start) begin
                run <= 1'b1;
            end
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (data_load[i]) begin
                    full_q[i] <= 1'b1;
                end else if (ack_user2interface[i]) begin
                    full_q[i] <= 1'b0;
                end
                if (cfg_load[i]) begin
                    route[i] <= route_t'(din_leaf_bft2interface.payload[$bits(route_t)-1:0]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (data_load[i]) begin
                word_q[i] <= din_leaf_bft2interface.payload;
            end
        end
    end

    assign dout_leaf_interface2user = word_q;
    assign vld_interface2user = full_q;

    // The kernel must have drained a port before the network sends it another word.
    assert property (@(posedge clk) disable iff (!arst_n)
        (data_hit & full_q & ~ack_user2interface) == '0)
        else $error("data packet arrived at a full slot");

endmodule

// File: user_kernel.sv
module user_kernel (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       run,
    input  leaf_pkg::word_t [leaf_pkg::NUM_PORTS-1:0]  dout_leaf_interface2user,
    input  logic [leaf_pkg::NUM_PORTS-1:0]             vld_interface2user,
    input  logic [leaf_pkg::NUM_PORTS-1:0]             ack_interface2user,
    output logic [leaf_pkg::NUM_PORTS-1:0]             ack_user2interface,
    output leaf_pkg::word_t [leaf_pkg::NUM_PORTS-1:0]  din_leaf_user2interface,
    output logic [leaf_pkg::NUM_PORTS-1:0]             vld_user2interface
);
    import leaf_pkg::*;

    slot_state_t [NUM_PORTS-1:0] state_q;
    word_t       [NUM_PORTS-1:0] sum_q;
    word_t       [NUM_PORTS-1:0] sum_next;
    logic        [NUM_PORTS-1:0] take;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            take[i] = run && vld_interface2user[i] && (state_q[i] == SLOT_IDLE);
            // Wraps modulo 2**32.
            sum_next[i] = sum_q[i] + dout_leaf_interface2user[i];
            vld_user2interface[i] = (state_q[i] == SLOT_BUSY);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q            <= {NUM_PORTS{SLOT_IDLE}};
            sum_q              <= '0;
            ack_user2interface <= '0;
        end else begin
            ack_user2interface <= take;
            for (int i = 0; i < NUM_PORTS; i++) begin
                case (state_q[i])
                    SLOT_IDLE: begin
                        if (take[i]) begin
                            sum_q[i]   <= sum_next[i];
                            state_q[i] <= SLOT_BUSY;
                        end
                    end
                    SLOT_BUSY: begin
                        if (ack_interface2user[i]) begin
                            state_q[i] <= SLOT_IDLE;
                        end
                    end
                    default: state_q[i] <= SLOT_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (take[i]) begin
                din_leaf_user2interface[i] <= sum_next[i];
            end
        end
    end

    // The router keeps its word valid until it sees this ack.
    assert property (@(posedge clk) disable iff (!arst_n)
        (ack_user2interface & ~vld_interface2user) == '0)
        else $error("kernel ack without a valid input word");

endmodule

// File: leaf_tx_port.sv
module leaf_tx_port #(
    parameter int PORT_ID = 1
) (
    input  logic              clk,
    input  logic              arst_n,
    input  leaf_pkg::word_t   din,
    input  logic              vld,
    input  leaf_pkg::route_t  route,
    input  logic              grant,
    output logic              ack,
    output logic              req,
    output leaf_pkg::packet_t pkt
);
    import leaf_pkg::*;

    logic   full_q;
    logic   load;
    route_t route_q;
    word_t  payload_q;

    assign load = vld && !full_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
            ack    <= 1'b0;
        end else begin
            ack <= load;
            if (load) begin
                full_q <= 1'b1;
            end else if (grant) begin
                full_q <= 1'b0;
            end
        end
    end

    // The route is sampled with the result so a later config write leaves it alone.
    always_ff @(posedge clk) begin
        if (load) begin
            route_q   <= route;
            payload_q <= din;
        end
    end

    assign req = full_q;
    assign pkt = '{valid:     full_q,
                   dest_leaf: route_q.dest_leaf,
                   dest_port: route_q.dest_port,
                   addr:      NUM_ADDR_BITS'(PORT_ID),
                   payload:   payload_q};

endmodule

// File: leaf_tx_arbiter.sv
module leaf_tx_arbiter (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic [leaf_pkg::NUM_PORTS-1:0]               req,
    input  leaf_pkg::packet_t [leaf_pkg::NUM_PORTS-1:0]  pkt,
    input  logic                                         resend,
    output logic [leaf_pkg::NUM_PORTS-1:0]               grant,
    output leaf_pkg::packet_t                            dout_leaf_interface2bft
);
    import leaf_pkg::*;

    logic [PORT_IDX_BITS-1:0] last_q;
    logic [PORT_IDX_BITS-1:0] pick;
    logic                     found;
    logic [PACKET_BITS-1:0]   link_q;

    // Search starts at the port after the last winner.
    always_comb begin
        int idx;
        pick  = last_q;
        found = 1'b0;
        for (int off = 1; off <= NUM_PORTS; off++) begin
            idx = (int'(last_q) + off) % NUM_PORTS;
            if (!found && req[idx]) begin
                found = 1'b1;
                pick  = PORT_IDX_BITS'(idx);
            end
        end
        grant = '0;
        if (found && !resend) begin
            grant[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_q <= PORT_IDX_BITS'(NUM_PORTS - 1);
            link_q <= '0;
        end else if (|grant) begin
            last_q <= pick;
            link_q <= pkt[pick];
        end else begin
            link_q <= '0;
        end
    end

    // Link reads zero for as long as the network asks for a resend.
    assign dout_leaf_interface2bft = resend ? '0 : packet_t'(link_q);

    // A tx port keeps its packet until the arbiter grants it.
    assert property (@(posedge clk) disable iff (!arst_n)
        ($past(req & ~grant) & ~req) == '0)
        else $error("tx port dropped its request before a grant");

endmodule

// File: leaf_top.sv
module leaf_top (
    input  logic              clk,
    input  logic              arst_n,
    input  leaf_pkg::packet_t din_leaf_bft2interface,
    output leaf_pkg::packet_t dout_leaf_interface2bft,
    input  logic              resend,
    input  logic              ap_start
);
    import leaf_pkg::*;

    word_t   [NUM_PORTS-1:0] dout_leaf_interface2user;
    logic    [NUM_PORTS-1:0] vld_interface2user;
    logic    [NUM_PORTS-1:0] ack_user2interface;
    word_t   [NUM_PORTS-1:0] din_leaf_user2interface;
    logic    [NUM_PORTS-1:0] vld_user2interface;
    logic    [NUM_PORTS-1:0] ack_interface2user;
    route_t  [NUM_PORTS-1:0] route;
    logic    [NUM_PORTS-1:0] req;
    logic    [NUM_PORTS-1:0] grant;
    packet_t [NUM_PORTS-1:0] pkt;
    logic                    run;

    leaf_rx_router u_rx_router (
        .clk                      (clk),
        .arst_n                   (arst_n),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .ap_start                 (ap_start),
        .ack_user2interface       (ack_user2interface),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .route                    (route),
        .run                      (run)
    );

    user_kernel u_user_kernel (
        .clk                      (clk),
        .arst_n                   (arst_n),
        .run                      (run),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_interface2user       (ack_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface)
    );

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_tx
        leaf_tx_port #(
            .PORT_ID (i + 1)
        ) u_tx_port (
            .clk    (clk),
            .arst_n (arst_n),
            .din    (din_leaf_user2interface[i]),
            .vld    (vld_user2interface[i]),
            .route  (route[i]),
            .grant  (grant[i]),
            .ack    (ack_interface2user[i]),
            .req    (req[i]),
            .pkt    (pkt[i])
        );
    end

    leaf_tx_arbiter u_tx_arbiter (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .req                     (req),
        .pkt                     (pkt),
        .resend                  (resend),
        .grant                   (grant),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

endmodule

// File: tb_leaf.sv
module tb_leaf;
    import leaf_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int STEPS = 19;
    localparam int CYCLES_PER_STEP = 40;
    localparam int CYCLE_LIMIT = STEPS * CYCLES_PER_STEP + RESET_CYCLES;

    typedef enum logic [2:0] {K_CFG, K_DATA, K_START, K_STRAY, K_BURST, K_RESEND} kind_t;

    typedef struct packed {
        kind_t      kind;
        logic [3:0] port;
        logic [6:0] addr;
        word_t      payload;
        logic       rnd;
    } step_t;

    logic    clk;
    logic    arst_n;
    packet_t din;
    packet_t dout;
    logic    resend;
    logic    ap_start;

    step_t   stim [STEPS];
    packet_t exp_q [$];
    packet_t got_q [$];
    // Words that reached a port before ap_start and the ports they went to.
    int      pend_q [$];
    word_t   pend_w [$];
    route_t  route_m [1:NUM_PORTS];
    word_t   sum_m [1:NUM_PORTS];
    bit      run_m;
    logic [31:0] rnd_state;
    int      errors;
    int      cycles;

    leaf_top u_leaf_top (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_random();
        rnd_state = xorshift32(rnd_state);
        return rnd_state;
    endfunction

    // Values seen at an edge belong to the cycle before it.
    always @(posedge clk) begin
        if (arst_n) begin
            if (resend) begin
                assert (dout == '0) else begin
                    errors++;
                    $display("FAILED t=%0t dout expected 0 got %h", $time, dout);
                end
            end else if (dout.valid) begin
                got_q.push_back(dout);
            end
        end
    end

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (exp_v === act_v) else begin
            errors++;
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp_v, act_v);
        end
    endtask

    function automatic packet_t data_pkt(input int k, input word_t w);
        packet_t p;
        p.valid = 1'b1;
        p.dest_leaf = LEAF_ID;
        p.dest_port = NUM_PORT_BITS'(k);
        p.addr = '0;
        p.payload = w;
        return p;
    endfunction

    // Adds a word to the model and queues the packet that port k should send for it.
    task automatic note_data(input int k, input word_t w);
        packet_t e;
        if (!run_m) begin
            pend_q.push_back(k);
            pend_w.push_back(w);
        end else begin
            sum_m[k] = sum_m[k] + w;
            e.valid = 1'b1;
            e.dest_leaf = route_m[k].dest_leaf;
            e.dest_port = route_m[k].dest_port;
            e.addr = NUM_ADDR_BITS'(k);
            e.payload = sum_m[k];
            exp_q.push_back(e);
        end
    endtask

    task automatic drive_pkt(input packet_t p);
        @(posedge clk);
        din <= p;
    endtask

    task automatic idle_link();
        @(posedge clk);
        din <= '0;
    endtask

    task automatic load_ports();
        word_t w;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            w = next_random();
            note_data(k, w);
            drive_pkt(data_pkt(k, w));
        end
        idle_link();
    endtask

    task automatic expect_silence(input int n, input string what);
        repeat (n) @(posedge clk);
        assert (got_q.size() == 0) else begin
            errors++;
            $display("An output packet appeared %s at t=%0t", what, $time);
        end
        got_q.delete();
    endtask

    // Matches each output packet to the oldest expected packet of the same source port.
    task automatic collect(input bit fair);
        int n;
        int idx;
        packet_t g;
        packet_t e;
        logic [(1 << NUM_ADDR_BITS)-1:0] served;
        n = exp_q.size();
        while (got_q.size() < n) @(posedge clk);
        repeat (4) @(posedge clk);
        check_field("packet count", n, got_q.size());
        served = '0;
        foreach (got_q[j]) begin
            g = got_q[j];
            if (fair && j < NUM_PORTS) begin
                assert (!served[g.addr]) else begin
                    errors++;
                    $display("Port %0d was served twice while another port waited", g.addr);
                end
                served[g.addr] = 1'b1;
            end
            idx = -1;
            foreach (exp_q[i]) begin
                if (idx < 0 && exp_q[i].addr == g.addr) idx = i;
            end
            if (idx < 0) begin
                errors++;
                $display("An output packet from port %0d was not expected", g.addr);
            end else begin
                e = exp_q[idx];
                check_field("dout.dest_leaf", e.dest_leaf, g.dest_leaf);
                check_field("dout.dest_port", e.dest_port, g.dest_port);
                check_field("dout.payload", e.payload, g.payload);
                exp_q.delete(idx);
            end
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected packets never appeared on the link", exp_q.size());
        end
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic fill_stim();
        stim[0]  = '{K_CFG,    4'd0, 7'd1, 32'h0000_0032, 1'b0};
        stim[1]  = '{K_CFG,    4'd0, 7'd2, 32'h0000_0115, 1'b0};
        stim[2]  = '{K_CFG,    4'd0, 7'd3, 32'h0000_0091, 1'b0};
        stim[3]  = '{K_DATA,   4'd1, 7'd0, 32'h0000_0010, 1'b0};
        stim[4]  = '{K_START,  4'd0, 7'd0, 32'h0000_0000, 1'b0};
        stim[5]  = '{K_DATA,   4'd2, 7'd0, 32'h0000_1234, 1'b0};
        stim[6]  = '{K_DATA,   4'd3, 7'd0, 32'hffff_fff0, 1'b0};
        stim[7]  = '{K_DATA,   4'd3, 7'd0, 32'h0000_0025, 1'b0};
        stim[8]  = '{K_CFG,    4'd0, 7'd0, 32'h0000_01ff, 1'b0};
        stim[9]  = '{K_DATA,   4'd1, 7'd0, 32'h0000_0000, 1'b1};
        stim[10] = '{K_STRAY,  4'd2, 7'd0, 32'h5555_5555, 1'b0};
        stim[11] = '{K_STRAY,  4'd3, 7'd1, 32'haaaa_aaaa, 1'b0};
        stim[12] = '{K_DATA,   4'd2, 7'd0, 32'h0000_0000, 1'b1};
        stim[13] = '{K_CFG,    4'd0, 7'd1, 32'h1234_51e7, 1'b0};
        stim[14] = '{K_DATA,   4'd1, 7'd0, 32'h8000_0000, 1'b0};
        stim[15] = '{K_BURST,  4'd0, 7'd0, 32'h0000_0000, 1'b1};
        stim[16] = '{K_DATA,   4'd3, 7'd0, 32'h0000_0000, 1'b1};
        stim[17] = '{K_RESEND, 4'd0, 7'd0, 32'h0000_0000, 1'b1};
        stim[18] = '{K_BURST,  4'd0, 7'd0, 32'h0000_0000, 1'b1};
    endtask

    initial begin
        step_t   s;
        word_t   w;
        packet_t p;
        din = '0;
        resend = 1'b0;
        ap_start = 1'b0;
        arst_n = 1'b0;
        errors = 0;
        run_m = 1'b0;
        rnd_state = 32'hb82e_2cb2;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            route_m[k] = '0;
            sum_m[k] = '0;
        end
        fill_stim();
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        foreach (stim[i]) begin
            s = stim[i];
            w = s.rnd ? next_random() : s.payload;
            case (s.kind)
                K_CFG: begin
                    p = data_pkt(CFG_PORT, w);
                    p.addr = s.addr;
                    drive_pkt(p);
                    idle_link();
                    if (s.addr >= 1 && s.addr <= NUM_PORTS) route_m[s.addr] = route_t'(w[8:0]);
                end
                K_DATA: begin
                    note_data(s.port, w);
                    drive_pkt(data_pkt(s.port, w));
                    idle_link();
                    if (run_m) collect(1'b0);
                    else expect_silence(20, "before ap_start");
                end
                K_START: begin
                    @(posedge clk);
                    ap_start <= 1'b1;
                    @(posedge clk);
                    ap_start <= 1'b0;
                    run_m = 1'b1;
                    while (pend_q.size() > 0) note_data(pend_q.pop_front(), pend_w.pop_front());
                    collect(1'b0);
                end
                K_STRAY: begin
                    p = data_pkt(s.port, w);
                    if (s.addr == 0) p.dest_leaf = LEAF_ID + 5'd1;
                    else p.valid = 1'b0;
                    drive_pkt(p);
                    idle_link();
                    expect_silence(10, "for a packet that is not for this leaf");
                end
                K_BURST: begin
                    load_ports();
                    collect(1'b0);
                end
                K_RESEND: begin
                    @(posedge clk);
                    resend <= 1'b1;
                    load_ports();
                    repeat (4) @(posedge clk);
                    load_ports();
                    repeat (12) @(posedge clk);
                    resend <= 1'b0;
                    collect(1'b1);
                end
                default: begin
                    errors++;
                    $display("Step %0d has an unknown kind", i);
                end
            endcase
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Errors: %0d", errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: list.f
leaf_pkg.sv
leaf_rx_router.sv
user_kernel.sv
leaf_tx_port.sv
leaf_tx_arbiter.sv
leaf_top.sv
tb_leaf.sv

// File: Bender.yml
package:
  name: leaf

sources:
  - leaf_pkg.sv
  - leaf_rx_router.sv
  - user_kernel.sv
  - leaf_tx_port.sv
  - leaf_tx_arbiter.sv
  - leaf_top.sv
  - target: simulation
    files:
      - tb_leaf.sv
